// File: verilog/castle_pkg.sv
/* castle drawing engine shared types
   coordinates, colours, rectangle commands, palette and default video mode */

package castle_pkg;

    typedef logic signed [15:0] coord_t;  // screen or framebuffer position
    typedef logic [3:0] cidx_t;           // palette index, 0 is empty
    typedef logic [3:0] chan_t;           // one colour channel

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // inclusive corners, x0 <= x1 and y0 <= y1
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } rect_cmd_t;

    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h135, 12'h725, 12'h085,  // black, dark blue, dark purple, dark green
        12'hA53, 12'h655, 12'hCCC, 12'hFFE,  // brown, dark grey, light grey, white
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3,  // red, orange, yellow, green
        12'h2AF, 12'h879, 12'hF7A, 12'hFCA   // blue, lavender, pink, peach
    };

    localparam rgb_t BG_COLR = 12'h239;  // sky blue behind empty pixels

    // small mode keeps simulation short
    localparam int H_ACTIVE = 64;
    localparam int H_FP     = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BP     = 4;
    localparam int V_ACTIVE = 36;
    localparam int V_FP     = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 2;
    localparam int FB_SCALE = 2;

endpackage

// File: verilog/fb_write_if.sv
/* framebuffer pixel write channel
   one write per clock while we is high, no back-pressure */

`timescale 1ns/1ps

interface fb_write_if import castle_pkg::*; ();

    logic   we;    // write enable
    coord_t x;     // framebuffer column
    coord_t y;     // framebuffer row
    cidx_t  cidx;  // colour index to store

    modport source (output we, x, y, cidx);
    modport sink   (input we, x, y, cidx);

endinterface

// File: verilog/display_timing.sv
/* display timing generator
   counts screen position and flags sync, active area, frame and line starts */

`timescale 1ns/1ps

module display_timing import castle_pkg::*; #(
    parameter int H_ACTIVE = castle_pkg::H_ACTIVE,
    parameter int H_FP     = castle_pkg::H_FP,
    parameter int H_SYNC   = castle_pkg::H_SYNC,
    parameter int H_BP     = castle_pkg::H_BP,
    parameter int V_ACTIVE = castle_pkg::V_ACTIVE,
    parameter int V_FP     = castle_pkg::V_FP,
    parameter int V_SYNC   = castle_pkg::V_SYNC,
    parameter int V_BP     = castle_pkg::V_BP
) (
    input  logic   clk_pix,
    input  logic   arst_n,
    output coord_t sx,
    output coord_t sy,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output logic   frame,
    output logic   line
);

    localparam int HS_START = H_ACTIVE + H_FP;
    localparam int HS_END   = HS_START + H_SYNC;  // first pixel after sync
    localparam int H_TOTAL  = HS_END + H_BP;
    localparam int VS_START = V_ACTIVE + V_FP;
    localparam int VS_END   = VS_START + V_SYNC;
    localparam int V_TOTAL  = VS_END + V_BP;

    coord_t nx, ny;  // position on the next clock

    always_comb begin
        nx = sx + 16'sd1;
        ny = sy;
        if (sx == H_TOTAL - 1) begin
            nx = '0;
            ny = (sy == V_TOTAL - 1) ? '0 : sy + 16'sd1;
        end
    end

    // flags are computed from the next position so they line up with sx/sy
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= coord_t'(H_TOTAL - 1);  // last pixel, frame starts right after reset
            sy    <= coord_t'(V_TOTAL - 1);
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= nx;
            sy    <= ny;
            hsync <= (nx >= HS_START) && (nx < HS_END);
            vsync <= (ny >= VS_START) && (ny < VS_END);
            de    <= (nx < H_ACTIVE) && (ny < V_ACTIVE);
            frame <= (nx == 0) && (ny == 0);
            line  <= (nx == 0);
        end
    end

endmodule

// File: verilog/rect_fill.sv
/* filled rectangle walker
   emits every pixel of an inclusive rectangle in row-major order, one per clock */

`timescale 1ns/1ps

module rect_fill import castle_pkg::*; (
    input  logic      clk_pix,
    input  logic      arst_n,
    input  logic      start,
    input  rect_cmd_t cmd,
    output coord_t    x,
    output coord_t    y,
    output logic      drawing,
    output logic      done
);

    coord_t x0_r;  // row restart column
    coord_t x1_r;
    coord_t y1_r;

    assign done = drawing && (x == x1_r) && (y == y1_r);  // last pixel is on x/y now

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            drawing <= 1'b0;
        end else if (start) begin
            drawing <= 1'b1;
        end else if (done) begin
            drawing <= 1'b0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (start) begin
            x0_r <= cmd.x0;
            x1_r <= cmd.x1;
            y1_r <= cmd.y1;
            x    <= cmd.x0;
            y    <= cmd.y0;
        end else if (drawing) begin
            if (x == x1_r) begin  // end of row
                x <= x0_r;
                y <= y + 16'sd1;
            end else begin
                x <= x + 16'sd1;
            end
        end
    end

endmodule

// File: verilog/draw_ctrl.sv
/* drawing controller
   clears the framebuffer after reset, then fills rectangles on command */

`timescale 1ns/1ps

module draw_ctrl import castle_pkg::*; #(
    parameter int FB_WIDTH  = castle_pkg::H_ACTIVE / castle_pkg::FB_SCALE,
    parameter int FB_HEIGHT = castle_pkg::V_ACTIVE / castle_pkg::FB_SCALE
) (
    input  logic      clk_pix,
    input  logic      arst_n,
    input  logic      cmd_valid,
    input  rect_cmd_t cmd,
    output logic      busy,
    fb_write_if.source wr
);

    typedef enum logic [1:0] {
        CLEAR,
        IDLE,
        DRAW
    } state_t;

    state_t state;
    coord_t clr_x, clr_y;  // clear sweep position
    cidx_t  cidx_r;        // colour of the rectangle being drawn
    logic   fill_start;
    coord_t fill_x, fill_y;
    logic   fill_drawing, fill_done;

    assign busy       = (state != IDLE);
    assign fill_start = (state == IDLE) && cmd_valid;  // commands while busy are dropped

    rect_fill u_rect_fill (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .start   (fill_start),
        .cmd     (cmd),
        .x       (fill_x),
        .y       (fill_y),
        .drawing (fill_drawing),
        .done    (fill_done)
    );

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= CLEAR;
            clr_x <= '0;
            clr_y <= '0;
            wr.we <= 1'b0;
        end else begin
            wr.we <= (state == CLEAR) || fill_drawing;
            case (state)
                CLEAR: begin
                    if (clr_x == FB_WIDTH - 1) begin
                        clr_x <= '0;
                        clr_y <= clr_y + 16'sd1;
                        if (clr_y == FB_HEIGHT - 1) state <= IDLE;  // whole buffer written
                    end else begin
                        clr_x <= clr_x + 16'sd1;
                    end
                end
                IDLE:    if (cmd_valid) state <= DRAW;
                DRAW:    if (fill_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // write payload, registered alongside we
    always_ff @(posedge clk_pix) begin
        if (fill_start) cidx_r <= cmd.cidx;
        if (state == CLEAR) begin
            wr.x    <= clr_x;
            wr.y    <= clr_y;
            wr.cidx <= '0;  // empty
        end else begin
            wr.x    <= fill_x;
            wr.y    <= fill_y;
            wr.cidx <= cidx_r;
        end
    end

endmodule

// File: verilog/framebuffer.sv
/* colour-index framebuffer
   stores one index per pixel, reads at scaled screen position through the palette */

`timescale 1ns/1ps

module framebuffer import castle_pkg::*; #(
    parameter int FB_WIDTH  = castle_pkg::H_ACTIVE / castle_pkg::FB_SCALE,
    parameter int FB_HEIGHT = castle_pkg::V_ACTIVE / castle_pkg::FB_SCALE,
    parameter int FB_SCALE  = castle_pkg::FB_SCALE
) (
    input  logic   clk_pix,
    fb_write_if.sink wr,
    input  coord_t sx,
    input  coord_t sy,
    input  logic   de,
    output rgb_t   pix_rgb,
    output logic   pix_empty
);

    localparam int DEPTH = FB_WIDTH * FB_HEIGHT;
    localparam int AW    = $clog2(DEPTH);

    cidx_t mem [DEPTH];

    logic          wr_ok;
    logic [AW-1:0] wr_addr;
    int            fx, fy;  // framebuffer position of the screen pixel
    logic          rd_ok;
    logic [AW-1:0] rd_addr;
    cidx_t         rd_idx;
    logic          rd_de;

    always_comb begin
        wr_ok   = (wr.x >= 0) && (wr.x < FB_WIDTH) && (wr.y >= 0) && (wr.y < FB_HEIGHT);
        wr_addr = AW'(int'(wr.y) * FB_WIDTH + int'(wr.x));
    end

    always_comb begin
        fx      = int'(sx) / FB_SCALE;
        fy      = int'(sy) / FB_SCALE;
        rd_ok   = (sx >= 0) && (sy >= 0) && (fx < FB_WIDTH) && (fy < FB_HEIGHT);
        rd_addr = rd_ok ? AW'(fy * FB_WIDTH + fx) : '0;
    end

    always_ff @(posedge clk_pix) begin
        if (wr.we && wr_ok) mem[wr_addr] <= wr.cidx;  // off-buffer writes are dropped
    end

    always_ff @(posedge clk_pix) begin
        rd_idx <= mem[rd_addr];
        rd_de  <= de && rd_ok;
    end

    assign pix_rgb   = PALETTE[rd_idx];
    assign pix_empty = !rd_de || (rd_idx == '0);

endmodule

// File: verilog/video_out.sv
/* video output stage
   delays sync to match the framebuffer read and picks the final pixel colour */

`timescale 1ns/1ps

module video_out import castle_pkg::*; (
    input  logic  clk_pix,
    input  logic  arst_n,
    input  logic  hsync_in,
    input  logic  vsync_in,
    input  logic  de_in,
    input  rgb_t  pix_rgb,
    input  logic  pix_empty,
    output logic  hsync,
    output logic  vsync,
    output logic  de,
    output chan_t red,
    output chan_t green,
    output chan_t blue
);

    logic hsync_d, vsync_d, de_d;  // aligned with framebuffer read data
    rgb_t colr;

    always_comb begin
        if (!de_d) colr = '0;                // blanking is black
        else if (pix_empty) colr = BG_COLR;
        else colr = pix_rgb;
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
            de_d    <= 1'b0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
            de      <= 1'b0;
            red     <= '0;
            green   <= '0;
            blue    <= '0;
        end else begin
            hsync_d <= hsync_in;
            vsync_d <= vsync_in;
            de_d    <= de_in;
            hsync   <= hsync_d;
            vsync   <= vsync_d;
            de      <= de_d;
            red     <= colr.r;
            green   <= colr.g;
            blue    <= colr.b;
        end
    end

endmodule

// File: verilog/castle_top.sv
/* rectangle drawing engine top
   draw commands fill a scaled framebuffer that is scanned out as 12-bit video */

`timescale 1ns/1ps

module castle_top import castle_pkg::*; (
    input  logic   clk_pix,
    input  logic   arst_n,
    input  logic   cmd_valid,  // one-cycle command strobe
    input  coord_t cmd_x0,
    input  coord_t cmd_y0,
    input  coord_t cmd_x1,
    input  coord_t cmd_y1,
    input  cidx_t  cmd_cidx,
    output logic   draw_busy,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output chan_t  red,
    output chan_t  green,
    output chan_t  blue
);

    localparam int FB_WIDTH  = H_ACTIVE / FB_SCALE;  // 32
    localparam int FB_HEIGHT = V_ACTIVE / FB_SCALE;  // 18

    rect_cmd_t cmd;
    coord_t    sx, sy;
    logic      tim_hsync, tim_vsync, tim_de;
    rgb_t      pix_rgb;
    logic      pix_empty;

    fb_write_if fb_wr ();

    assign cmd = '{x0: cmd_x0, y0: cmd_y0, x1: cmd_x1, y1: cmd_y1, cidx: cmd_cidx};

    display_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) u_display_timing (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (tim_hsync),
        .vsync   (tim_vsync),
        .de      (tim_de),
        .frame   (),
        .line    ()
    );

    draw_ctrl #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_draw_ctrl (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (draw_busy),
        .wr        (fb_wr.source)
    );

    framebuffer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .FB_SCALE  (FB_SCALE)
    ) u_framebuffer (
        .clk_pix   (clk_pix),
        .wr        (fb_wr.sink),
        .sx        (sx),
        .sy        (sy),
        .de        (tim_de),
        .pix_rgb   (pix_rgb),
        .pix_empty (pix_empty)
    );

    video_out u_video_out (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .hsync_in  (tim_hsync),
        .vsync_in  (tim_vsync),
        .de_in     (tim_de),
        .pix_rgb   (pix_rgb),
        .pix_empty (pix_empty),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

// File: sim/tb_castle.sv
/* castle drawing engine testbench
   replays draw commands from the case file and checks whole displayed frames */

`timescale 1ns/1ps

module tb_castle import castle_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int FB_W       = H_ACTIVE / FB_SCALE;
    localparam int FB_H       = V_ACTIVE / FB_SCALE;
    localparam int H_TOTAL    = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL    = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME      = H_TOTAL * V_TOTAL;  // clocks per frame
    localparam int CLEAR      = FB_W * FB_H;
    localparam int SLACK      = 32;                 // strobe, gap and edge search overhead
    localparam int MAX_CASES  = 32;

    logic   clk_pix, arst_n, cmd_valid;
    coord_t cmd_x0, cmd_y0, cmd_x1, cmd_y1;
    cidx_t  cmd_cidx;
    logic   draw_busy, hsync, vsync, de;
    chan_t  red, green, blue;

    logic [15:0] case_mem [MAX_CASES * 6];  // op x0 y0 x1 y1 cidx per case
    cidx_t       ref_fb [FB_H][FB_W];       // expected framebuffer contents
    int          n_cases, max_area, limit_cycles;
    logic        limit_ready;

    castle_top u_castle_top (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_x0    (cmd_x0),
        .cmd_y0    (cmd_y0),
        .cmd_x1    (cmd_x1),
        .cmd_y1    (cmd_y1),
        .cmd_cidx  (cmd_cidx),
        .draw_busy (draw_busy),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    function automatic int case_coord(input int k, input int f);
        return int'(coord_t'(case_mem[k * 6 + f]));  // sign extended
    endfunction

    // outputs while reset holds and just after
    task automatic check_quiet_outputs();
        check_flag("de", 1'b0, de);
        check_flag("hsync", 1'b0, hsync);
        check_flag("vsync", 1'b0, vsync);
        check_rgb("rgb", 12'h000, {red, green, blue});
        check_flag("draw_busy", 1'b1, draw_busy);
    endtask

    task automatic wait_idle(input int bound);
        int n;
        n = 0;
        while (draw_busy !== 1'b0) begin
            if (n >= bound) begin
                $display("draw_busy stayed high for more than %0d cycles", bound);
                stop_run();
            end
            @(negedge clk_pix);
            n++;
        end
    endtask

    task automatic wait_vsync();
        logic prev, seen;
        int   n;
        seen = 1'b0;
        n    = 0;
        while (!seen) begin
            prev = vsync;
            @(negedge clk_pix);
            seen = vsync && !prev;
            n++;
            if (!seen && n > FRAME + SLACK) begin
                $display("no vsync seen within %0d cycles", FRAME + SLACK);
                stop_run();
            end
        end
    endtask

    task automatic send_cmd(input int k);
        cmd_x0    = coord_t'(case_mem[k * 6 + 1]);
        cmd_y0    = coord_t'(case_mem[k * 6 + 2]);
        cmd_x1    = coord_t'(case_mem[k * 6 + 3]);
        cmd_y1    = coord_t'(case_mem[k * 6 + 4]);
        cmd_cidx  = cidx_t'(case_mem[k * 6 + 5]);
        cmd_valid = 1'b1;
        @(negedge clk_pix);
        cmd_valid = 1'b0;
        check_flag("draw_busy", 1'b1, draw_busy);  // busy the cycle after the strobe
    endtask

    task automatic paint_ref(input int k);
        int x, y, xa, xb, ya, yb;
        xa = (case_coord(k, 1) < 0) ? 0 : case_coord(k, 1);  // clip to the buffer
        ya = (case_coord(k, 2) < 0) ? 0 : case_coord(k, 2);
        xb = (case_coord(k, 3) >= FB_W) ? FB_W - 1 : case_coord(k, 3);
        yb = (case_coord(k, 4) >= FB_H) ? FB_H - 1 : case_coord(k, 4);
        for (y = ya; y <= yb; y++) begin
            for (x = xa; x <= xb; x++) begin
                ref_fb[y][x] = cidx_t'(case_mem[k * 6 + 5]);
            end
        end
    endtask

    // pixel position comes from counting de cycles after vsync
    task automatic check_frame();
        int    pix, run, lines, n, hpos, vs_high;
        logic  prev_de, prev_vs, done_f;
        cidx_t idx;
        rgb_t  exp;
        wait_vsync();
        pix     = 0;
        run     = 0;
        lines   = 0;
        n       = 0;
        hpos    = -1;  // unknown until the first active line ends
        vs_high = 1;   // the rising edge itself
        prev_de = 1'b0;
        prev_vs = 1'b1;
        done_f  = 1'b0;
        while (!done_f) begin
            @(negedge clk_pix);
            n++;
            if (vsync && !prev_vs) begin
                done_f = 1'b1;  // next frame begins
            end else if (n > FRAME + SLACK) begin
                $display("no vsync at the end of a frame");
                stop_run();
            end else if (de) begin
                if (pix >= H_ACTIVE * V_ACTIVE) begin
                    $display("more than %0d active pixels in one frame", H_ACTIVE * V_ACTIVE);
                    stop_run();
                end
                idx = ref_fb[(pix / H_ACTIVE) / FB_SCALE][(pix % H_ACTIVE) / FB_SCALE];
                exp = (idx == 4'd0) ? BG_COLR : PALETTE[idx];
                check_rgb("rgb", exp, {red, green, blue});
                check_flag("hsync", 1'b0, hsync);
                check_flag("vsync", 1'b0, vsync);
                pix++;
                run++;
                hpos = run;  // column of the next pixel
            end else begin
                if (prev_de) begin
                    if (run != H_ACTIVE) begin
                        $display("line %0d had %0d active pixels instead of %0d",
                                 lines, run, H_ACTIVE);
                        stop_run();
                    end
                    lines++;
                    run = 0;
                end
                if (hpos >= 0) begin
                    check_flag("hsync",
                               ((hpos % H_TOTAL) >= H_ACTIVE + H_FP) &&
                               ((hpos % H_TOTAL) < H_ACTIVE + H_FP + H_SYNC), hsync);
                    hpos++;
                end
                check_rgb("rgb", 12'h000, {red, green, blue});  // blanking is black
            end
            if (vsync && !done_f) vs_high++;
            prev_de = de;
            prev_vs = vsync;
        end
        if (lines != V_ACTIVE) begin
            $display("frame had %0d active lines instead of %0d", lines, V_ACTIVE);
            stop_run();
        end
        if (vs_high != V_SYNC * H_TOTAL) begin
            $display("vsync was high for %0d cycles instead of %0d",
                     vs_high, V_SYNC * H_TOTAL);
            stop_run();
        end
    endtask

    // watchdog armed once the case count is known
    initial begin
        wait (limit_ready === 1'b1);
        repeat (limit_cycles) @(posedge clk_pix);
        $display("watchdog expired after %0d cycles, the run is hung", limit_cycles);
        stop_run();
    end

    initial begin
        int i, area;
        arst_n      = 1'b0;
        cmd_valid   = 1'b0;
        cmd_x0      = '0;
        cmd_y0      = '0;
        cmd_x1      = '0;
        cmd_y1      = '0;
        cmd_cidx    = '0;
        limit_ready = 1'b0;
        void'($urandom(32'h5075fdd6));
        $readmemh("sim/castle_cases.txt", case_mem);

        n_cases  = 0;
        max_area = 1;
        while (n_cases < MAX_CASES && (case_mem[n_cases * 6] == 16'd1 ||
               case_mem[n_cases * 6] == 16'd2 || case_mem[n_cases * 6] == 16'd3)) begin
            area = (case_coord(n_cases, 3) - case_coord(n_cases, 1) + 1) *
                   (case_coord(n_cases, 4) - case_coord(n_cases, 2) + 1);
            if (area > max_area) max_area = area;
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("case file holds no usable cases");
            stop_run();
        end
        limit_cycles = n_cases * (max_area + 2 * FRAME + SLACK) + CLEAR + 4 + SLACK;
        limit_ready  = 1'b1;

        for (int y = 0; y < FB_H; y++) begin
            for (int x = 0; x < FB_W; x++) begin
                ref_fb[y][x] = 4'd0;  // cleared buffer
            end
        end

        repeat (4) begin
            @(negedge clk_pix);
            check_quiet_outputs();
        end
        arst_n = 1'b1;
        @(negedge clk_pix);
        check_quiet_outputs();
        wait_idle(CLEAR + 4);

        for (i = 0; i < n_cases; i++) begin
            case (case_mem[i * 6])
                16'd1: begin
                    wait_idle(max_area + SLACK);
                    repeat ($urandom % 8) @(negedge clk_pix);  // idle gap
                    send_cmd(i);
                    paint_ref(i);
                end
                16'd3: begin
                    check_flag("draw_busy", 1'b1, draw_busy);  // engine must still be drawing
                    send_cmd(i);
                end
                default: begin
                    wait_idle(max_area + SLACK);
                    check_frame();
                end
            endcase
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: sim/castle_cases.txt
// columns, all hex: op x0 y0 x1 y1 cidx, coordinates are 16-bit two's complement
// op 1 draw rectangle, op 3 draw while busy (ignored), op 2 check one frame, op 0 end
2 0000 0000 0000 0000 0
// single dark grey rectangle
1 0004 0003 000d 000a 5
2 0000 0000 0000 0000 0
// brown on top of the grey one
1 000a 0007 0015 000f 4
2 0000 0000 0000 0000 0
// long blue strip, then a command into the busy engine
1 0000 0000 001f 0003 c
3 0010 0008 0018 000c 2
2 0000 0000 0000 0000 0
// green band running off both side edges
1 fffe 000f 0022 0015 b
2 0000 0000 0000 0000 0
// pink corner past the right and bottom edges
1 001e 0010 0020 0013 e
2 0000 0000 0000 0000 0
0 0000 0000 0000 0000 0

// File: castle_top.f
verilog/castle_pkg.sv
verilog/fb_write_if.sv
verilog/display_timing.sv
verilog/rect_fill.sv
verilog/draw_ctrl.sv
verilog/framebuffer.sv
verilog/video_out.sv
verilog/castle_top.sv
sim/tb_castle.sv

// File: Makefile
# Verilator build and run for the castle drawing engine

VERILATOR ?= verilator
TOP       ?= tb_castle
LOG       ?= sim.log
FILELIST  ?= castle_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
